// ==== tiny_core.f ====
core_pkg.sv
mem_wrapper.sv
mem_arbiter.sv
prog_loader.sv
ifu.sv
idu.sv
exu.sv
tiny_core.sv
tb_clock.sv
tb_tiny_core.sv

// ==== Makefile ====
TB_TOP = tb_tiny_core

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module tiny_core -f tiny_core.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TB_TOP) -f tiny_core.f -o $(TB_TOP)
	./obj_dir/$(TB_TOP)

clean:
	rm -rf obj_dir

// ==== tb_tiny_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tiny_core;

    localparam int n_tests     = 6;
    localparam int max_words   = 16;
    localparam int max_wb      = 32;
    localparam int watchdog_ns = n_tests * 200 * 100;
    localparam logic [31:0] wfi = 32'h1050_0073;

    logic                      clk;
    logic                      arst_n;
    logic                      rst_req;
    logic                      load_vld;
    logic [31:0]               load_word;
    logic                      load_rdy;
    logic                      start_vld;
    logic [core_pkg::pc_w-1:0] start_addr;
    logic                      wb_vld;
    logic [3:0]                wb_rd;
    logic [31:0]               wb_data;
    logic                      halted;

    // stimulus table and the model's expected write-backs per run
    string       t_name   [n_tests];
    logic [31:0] t_prog   [n_tests][max_words];
    int          t_len    [n_tests];
    int          t_start  [n_tests];  // word offsets
    int          t_resume [n_tests];  // -1 when there is no second start
    logic        t_reset  [n_tests];
    int          t_base   [n_tests];  // first line of the program
    logic [3:0]  e_rd     [n_tests][2][max_wb];
    logic [31:0] e_val    [n_tests][2][max_wb];
    int          e_cnt    [n_tests][2];

    logic [31:0] model_mem [1024];
    logic [31:0] mregs [16];
    logic [31:0] lcg_state;
    int          load_line;

    tb_clock clk_gen_i (.rst_req(rst_req), .clk(clk), .arst_n(arst_n));

    tiny_core dut_i (
        .clk(clk), .arst_n(arst_n), .load_vld(load_vld), .load_word(load_word),
        .load_rdy(load_rdy), .start_vld(start_vld), .start_addr(start_addr),
        .wb_vld(wb_vld), .wb_rd(wb_rd), .wb_data(wb_data), .halted(halted)
    );

    task automatic abort(string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare_values(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            abort($sformatf("MISMATCH %s expected %0h actual %0h", name, exp, act));
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_imm();
        logic [31:0] r;
        r = next_rand();
        return int'($signed(r[31:20]));  // 12 bit signed
    endfunction

    function automatic logic [31:0] addi_ins(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'h13};
    endfunction

    function automatic logic [31:0] alu_ins(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                            int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] branch_ins(logic [2:0] f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] jal_ins(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic append_word(int i, logic [31:0] w);
        t_prog[i][t_len[i]] = w;
        t_len[i]++;
    endtask

    task automatic build_table();
        for (int i = 0; i < n_tests; i++) begin
            t_len[i]    = 0;
            t_start[i]  = 0;
            t_resume[i] = -1;
            t_reset[i]  = 1'b0;
        end
        t_name[0] = "straight_line";  // three full lines
        append_word(0, addi_ins(1, 0, rand_imm()));
        append_word(0, addi_ins(2, 0, rand_imm()));
        append_word(0, alu_ins(7'h00, 3'b000, 3, 1, 2));
        append_word(0, alu_ins(7'h20, 3'b000, 4, 3, 1));
        append_word(0, alu_ins(7'h00, 3'b100, 5, 4, 2));
        append_word(0, addi_ins(0, 1, rand_imm()));  // x0 target
        append_word(0, addi_ins(6, 5, rand_imm()));
        append_word(0, alu_ins(7'h20, 3'b000, 7, 2, 6));
        append_word(0, alu_ins(7'h00, 3'b000, 0, 7, 3));
        append_word(0, alu_ins(7'h00, 3'b100, 8, 7, 3));
        append_word(0, alu_ins(7'h00, 3'b000, 9, 8, 1));
        append_word(0, wfi);
        t_name[1] = "bne_loop";
        append_word(1, addi_ins(1, 0, 3));
        append_word(1, addi_ins(2, 0, 0));
        append_word(1, addi_ins(2, 2, rand_imm()));
        append_word(1, addi_ins(1, 1, -1));
        append_word(1, branch_ins(3'b001, 1, 0, -8));
        append_word(1, addi_ins(3, 2, rand_imm()));
        append_word(1, wfi);
        t_name[2] = "beq_jal";
        append_word(2, addi_ins(1, 0, 7));
        append_word(2, addi_ins(2, 0, 7));
        append_word(2, branch_ins(3'b000, 1, 2, 8));  // taken
        append_word(2, addi_ins(3, 0, 1));
        append_word(2, branch_ins(3'b000, 1, 0, 8));  // not taken
        append_word(2, addi_ins(4, 0, 2));
        append_word(2, jal_ins(5, 12));
        append_word(2, addi_ins(6, 0, 3));
        append_word(2, addi_ins(7, 0, 4));
        append_word(2, addi_ins(8, 5, rand_imm()));
        append_word(2, wfi);
        t_name[3]  = "unaligned_start";
        t_start[3] = 2;
        append_word(3, addi_ins(9, 0, 11));
        append_word(3, addi_ins(10, 0, 12));
        append_word(3, addi_ins(11, 0, rand_imm()));
        append_word(3, alu_ins(7'h00, 3'b000, 12, 11, 11));
        append_word(3, wfi);
        t_name[4]   = "wfi_resume";
        t_resume[4] = 4;
        append_word(4, addi_ins(1, 0, rand_imm()));
        append_word(4, wfi);
        append_word(4, addi_ins(15, 0, 1));  // never reached
        append_word(4, wfi);
        append_word(4, addi_ins(13, 1, rand_imm()));
        append_word(4, alu_ins(7'h20, 3'b000, 14, 13, 1));
        append_word(4, wfi);
        t_name[5]  = "reload_overwrite";
        t_reset[5] = 1'b1;  // loader back at line 0
        append_word(5, addi_ins(1, 0, rand_imm()));
        append_word(5, addi_ins(2, 1, rand_imm()));
        append_word(5, alu_ins(7'h00, 3'b100, 3, 1, 2));
        append_word(5, alu_ins(7'h20, 3'b000, 4, 3, 2));
        append_word(5, branch_ins(3'b001, 4, 1, 8));
        append_word(5, addi_ins(5, 0, 1));
        append_word(5, wfi);
        for (int i = 0; i < n_tests; i++) begin
            while (t_len[i] % 4 != 0) begin
                append_word(i, wfi);  // loader writes whole lines only
            end
        end
    endtask

    // ISA reference model from pc0 up to the first wfi
    task automatic model_run(int i, int run, logic [11:0] pc0);
        logic [11:0] pc;
        logic [11:0] nxt;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        wr;
        int          steps;
        pc            = pc0;
        steps         = 0;
        e_cnt[i][run] = 0;
        ins           = model_mem[pc[11:2]];
        while (ins != wfi) begin
            if (steps == 100) begin
                abort($sformatf("%s: reference model never reached wfi", t_name[i]));
            end
            a   = mregs[ins[18:15]];
            b   = mregs[ins[23:20]];
            wr  = 1'b0;
            res = '0;
            nxt = pc + 12'd4;
            case (ins[6:0])
                7'h13: begin
                    res = a + {{20{ins[31]}}, ins[31:20]};
                    wr  = 1'b1;
                end
                7'h33: begin
                    res = ins[14] ? a ^ b : (ins[30] ? a - b : a + b);
                    wr  = 1'b1;
                end
                7'h63: begin
                    if ((a == b) != ins[12]) begin
                        nxt = pc + {ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                7'h6f: begin
                    res = {20'b0, pc} + 32'd4;
                    wr  = 1'b1;
                    nxt = pc + {ins[20], ins[30:21], 1'b0};
                end
                default: ;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                mregs[ins[10:7]]             = res;
                e_rd[i][run][e_cnt[i][run]]  = ins[10:7];
                e_val[i][run][e_cnt[i][run]] = res;
                e_cnt[i][run]++;
            end
            pc  = nxt;
            ins = model_mem[pc[11:2]];
            steps++;
        end
    endtask

    task automatic apply_reset();
        rst_req = 1'b1;
        wait (arst_n === 1'b0);
        rst_req = 1'b0;
        wait (arst_n === 1'b1);
        load_line = 0;
        for (int r = 0; r < 16; r++) begin
            mregs[r] = '0;
        end
    endtask

    task automatic load_program(int i);
        int w;
        w         = 0;
        t_base[i] = load_line;
        while (w < t_len[i]) begin
            @(negedge clk);
            load_vld  = load_rdy;
            load_word = t_prog[i][w];
            if (load_rdy) begin
                model_mem[load_line * 4 + w] = t_prog[i][w];
                w++;
            end
        end
        @(negedge clk);
        load_vld = 1'b0;
        while (!load_rdy) begin
            @(negedge clk);  // last line still waiting for its grant
        end
        load_line += t_len[i] / 4;
    endtask

    task automatic run_program(int i, int run, int off);
        logic [11:0] addr;
        int          n;
        addr = 12'((t_base[i] * 4 + off) * 4);
        model_run(i, run, addr);
        @(negedge clk);
        start_vld  = 1'b1;
        start_addr = addr;
        @(negedge clk);
        start_vld = 1'b0;
        n         = 0;
        while (!halted) begin
            if (wb_vld) begin
                if (n == e_cnt[i][run]) begin
                    abort($sformatf("%s: unexpected extra write-back to x%0d", t_name[i], wb_rd));
                end
                compare_values($sformatf("%s run %0d wb %0d rd", t_name[i], run, n),
                               32'(e_rd[i][run][n]), 32'(wb_rd));
                compare_values($sformatf("%s run %0d wb %0d data", t_name[i], run, n),
                               e_val[i][run][n], wb_data);
                n++;
            end
            @(negedge clk);
        end
        if (n != e_cnt[i][run]) begin
            abort($sformatf("%s: halted after %0d of %0d write-backs", t_name[i], n,
                            e_cnt[i][run]));
        end
        repeat (4) begin
            if (wb_vld) begin
                abort($sformatf("%s: write-back while the core is halted", t_name[i]));
            end
            compare_values($sformatf("%s run %0d halted", t_name[i], run), 32'd1, 32'(halted));
            @(negedge clk);
        end
    endtask

    initial begin
        #(watchdog_ns);
        abort("timeout, the tests did not finish within the watchdog limit");
    end

    initial begin
        rst_req    = 1'b0;
        load_vld   = 1'b0;
        load_word  = '0;
        start_vld  = 1'b0;
        start_addr = '0;
        lcg_state  = 32'hea50_3940;
        load_line  = 0;
        for (int r = 0; r < 16; r++) begin
            mregs[r] = '0;
        end
        build_table();
        wait (arst_n === 1'b1);
        for (int i = 0; i < n_tests; i++) begin
            if (t_reset[i]) begin
                apply_reset();
            end
            load_program(i);
            run_program(i, 0, t_start[i]);
            if (t_resume[i] >= 0) begin
                run_program(i, 1, t_resume[i]);
            end
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    input  wire  rst_req,
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        forever begin
            @(posedge rst_req);  // same 4 cycle reset on request
            @(negedge clk);
            arst_n = 1'b0;
            repeat (4) @(posedge clk);
            @(negedge clk);
            arst_n = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== tiny_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tiny_core (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        load_vld,
    input  wire  [31:0]                load_word,
    output logic                       load_rdy,
    input  wire                        start_vld,
    input  wire  [core_pkg::pc_w-1:0]  start_addr,
    output logic                       wb_vld,
    output logic [3:0]                 wb_rd,
    output logic [31:0]                wb_data,
    output logic                       halted
);

    logic                              fetch_ce;
    logic [core_pkg::line_addr_w-1:0]  fetch_addr;
    logic                              wr_req;
    logic                              wr_gnt;
    logic [core_pkg::line_addr_w-1:0]  wr_addr;
    logic [core_pkg::line_w-1:0]       wr_line;
    logic                              mem_ce;
    logic                              mem_we;
    logic [core_pkg::line_addr_w-1:0]  mem_addr;
    logic [core_pkg::line_w-1:0]       mem_din;
    logic [core_pkg::line_w-1:0]       ifu_idu_ins_raw;
    logic                              ifu_idu_vld;
    logic [31:0]                       ifu_idu_ins;
    logic [31:0]                       ifu_idu_pc;
    logic                              idu_ifu_rdy;
    logic                              idu_ifu_wfi;
    logic                              dec_vld;
    core_pkg::dec_ins_t                dec_ins;
    logic                              alu_ifu_br_vld;
    logic [core_pkg::pc_w-1:0]         alu_ifu_br_addr;

    mem_wrapper #(
        .ADDR_WIDTH(core_pkg::line_addr_w),
        .DATA_WIDTH(core_pkg::line_w)
    ) u_mem (
        .clk(clk), .ce(mem_ce), .we(mem_we), .addr(mem_addr), .din(mem_din),
        .dout(ifu_idu_ins_raw)
    );

    mem_arbiter u_arb (
        .fetch_ce(fetch_ce), .fetch_addr(fetch_addr), .wr_req(wr_req), .wr_addr(wr_addr),
        .wr_line(wr_line), .wr_gnt(wr_gnt), .mem_ce(mem_ce), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_din(mem_din)
    );

    prog_loader u_loader (
        .clk(clk), .arst_n(arst_n), .load_vld(load_vld), .load_word(load_word),
        .load_rdy(load_rdy), .wr_req(wr_req), .wr_addr(wr_addr), .wr_line(wr_line),
        .wr_gnt(wr_gnt)
    );

    ifu u_ifu (
        .clk(clk), .arst_n(arst_n), .start_vld(start_vld), .start_addr(start_addr),
        .idu_ifu_rdy(idu_ifu_rdy), .idu_ifu_wfi(idu_ifu_wfi),
        .alu_ifu_br_vld(alu_ifu_br_vld), .alu_ifu_br_addr(alu_ifu_br_addr),
        .ifu_idu_ins_raw(ifu_idu_ins_raw), .ifu_idu_vld(ifu_idu_vld),
        .ifu_idu_ins(ifu_idu_ins), .ifu_idu_pc(ifu_idu_pc),
        .mem_ce(fetch_ce), .mem_addr(fetch_addr)
    );

    idu u_idu (
        .ifu_idu_vld(ifu_idu_vld), .ifu_idu_ins(ifu_idu_ins), .dec_vld(dec_vld),
        .dec_ins(dec_ins), .idu_ifu_rdy(idu_ifu_rdy), .idu_ifu_wfi(idu_ifu_wfi)
    );

    exu u_exu (
        .clk(clk), .arst_n(arst_n), .start_vld(start_vld), .dec_vld(dec_vld),
        .dec_ins(dec_ins), .pc(ifu_idu_pc), .alu_ifu_br_vld(alu_ifu_br_vld),
        .alu_ifu_br_addr(alu_ifu_br_addr), .wb_vld(wb_vld), .wb_rd(wb_rd),
        .wb_data(wb_data), .halted(halted)
    );

endmodule

`default_nettype wire

// ==== exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        start_vld,
    input  wire                        dec_vld,
    input  core_pkg::dec_ins_t         dec_ins,
    input  wire  [31:0]                pc,
    output logic                       alu_ifu_br_vld,
    output logic [core_pkg::pc_w-1:0]  alu_ifu_br_addr,
    output logic                       wb_vld,
    output logic [3:0]                 wb_rd,
    output logic [31:0]                wb_data,
    output logic                       halted
);

    logic [31:0] regs [16];
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic        eq;
    logic        taken;
    logic        halt_q;

    assign rs1_val = regs[dec_ins.rs1];  // x0 is never written
    assign rs2_val = regs[dec_ins.rs2];
    assign op_b    = dec_ins.use_imm ? dec_ins.imm : rs2_val;

    always_comb begin
        case (dec_ins.alu_op)
            core_pkg::ALU_SUB: alu_res = rs1_val - op_b;
            core_pkg::ALU_XOR: alu_res = rs1_val ^ op_b;
            default:           alu_res = rs1_val + op_b;
        endcase
    end

    assign eq    = rs1_val == rs2_val;
    assign taken = dec_ins.is_jal | dec_ins.is_beq & eq | dec_ins.is_bne & ~eq;

    assign alu_ifu_br_vld  = dec_vld & taken;
    assign alu_ifu_br_addr = pc[core_pkg::pc_w-1:0] + dec_ins.imm[core_pkg::pc_w-1:0];

    assign wb_vld  = dec_vld & dec_ins.wr_en & (dec_ins.rd != 4'd0);
    assign wb_rd   = dec_ins.rd;
    assign wb_data = dec_ins.is_jal ? pc + 32'd4 : alu_res;  // link value for jal

    assign halted = halt_q | dec_vld & dec_ins.is_wfi;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
            halt_q <= 1'b0;
        end else begin
            if (wb_vld) begin
                regs[wb_rd] <= wb_data;
            end
            if (start_vld) begin
                halt_q <= 1'b0;
            end else if (dec_vld && dec_ins.is_wfi) begin
                halt_q <= 1'b1;  // sticky until restart
            end
        end
    end

endmodule

`default_nettype wire

// ==== idu.sv ====
`timescale 1ns/1ps
`default_nettype none

module idu (
    input  wire                 ifu_idu_vld,
    input  wire  [31:0]         ifu_idu_ins,
    output logic                dec_vld,
    output core_pkg::dec_ins_t  dec_ins,
    output logic                idu_ifu_rdy,
    output logic                idu_ifu_wfi
);

    localparam logic [31:0] wfi_enc = 32'h1050_0073;

    core_pkg::opcode_e opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [31:0]       imm_i;
    logic [31:0]       imm_b;
    logic [31:0]       imm_j;

    assign opcode = core_pkg::opcode_e'(ifu_idu_ins[6:0]);
    assign funct3 = ifu_idu_ins[14:12];
    assign funct7 = ifu_idu_ins[31:25];

    assign imm_i = {{20{ifu_idu_ins[31]}}, ifu_idu_ins[31:20]};
    assign imm_b = {{19{ifu_idu_ins[31]}}, ifu_idu_ins[31], ifu_idu_ins[7],
                    ifu_idu_ins[30:25], ifu_idu_ins[11:8], 1'b0};
    assign imm_j = {{11{ifu_idu_ins[31]}}, ifu_idu_ins[31], ifu_idu_ins[19:12],
                    ifu_idu_ins[20], ifu_idu_ins[30:21], 1'b0};

    always_comb begin
        dec_ins     = '0;  // no-op unless matched below
        dec_ins.rd  = ifu_idu_ins[10:7];
        dec_ins.rs1 = ifu_idu_ins[18:15];
        dec_ins.rs2 = ifu_idu_ins[23:20];
        case (opcode)
            core_pkg::OP_IMM: begin
                if (funct3 == 3'b000) begin  // addi
                    dec_ins.imm     = imm_i;
                    dec_ins.use_imm = 1'b1;
                    dec_ins.wr_en   = 1'b1;
                end
            end
            core_pkg::OP: begin
                dec_ins.wr_en = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: dec_ins.alu_op = core_pkg::ALU_ADD;
                    10'b0100000_000: dec_ins.alu_op = core_pkg::ALU_SUB;
                    10'b0000000_100: dec_ins.alu_op = core_pkg::ALU_XOR;
                    default:         dec_ins.wr_en  = 1'b0;
                endcase
            end
            core_pkg::BRANCH: begin
                dec_ins.imm    = imm_b;
                dec_ins.is_beq = funct3 == 3'b000;
                dec_ins.is_bne = funct3 == 3'b001;
            end
            core_pkg::JAL: begin
                dec_ins.imm    = imm_j;
                dec_ins.is_jal = 1'b1;
                dec_ins.wr_en  = 1'b1;
            end
            core_pkg::SYSTEM: dec_ins.is_wfi = ifu_idu_ins == wfi_enc;
            default: ;
        endcase
    end

    assign dec_vld     = ifu_idu_vld;
    assign idu_ifu_rdy = ~dec_ins.is_wfi;
    assign idu_ifu_wfi = ifu_idu_vld & dec_ins.is_wfi;  // fetch stops after this one

endmodule

`default_nettype wire

// ==== ifu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifu (
    input  wire                               clk,
    input  wire                               arst_n,
    input  wire                               start_vld,
    input  wire  [core_pkg::pc_w-1:0]         start_addr,
    input  wire                               idu_ifu_rdy,
    input  wire                               idu_ifu_wfi,
    input  wire                               alu_ifu_br_vld,
    input  wire  [core_pkg::pc_w-1:0]         alu_ifu_br_addr,
    input  wire  [core_pkg::line_w-1:0]       ifu_idu_ins_raw,
    output logic                              ifu_idu_vld,
    output logic [31:0]                       ifu_idu_ins,
    output logic [31:0]                       ifu_idu_pc,
    output logic                              mem_ce,
    output logic [core_pkg::line_addr_w-1:0]  mem_addr
);

    localparam logic [core_pkg::pc_w-1:0] pc_step = 4;

    logic [core_pkg::pc_w-1:0] pc;
    logic [core_pkg::pc_w-1:0] pc_plus;
    logic [core_pkg::pc_w-1:0] pc_nxt;
    logic                      pc_en;
    logic                      vld_nxt;
    logic                      last_slot;

    assign pc_plus   = pc + pc_step;
    assign last_slot = &pc[3:2];
    assign pc_en     = ifu_idu_vld & idu_ifu_rdy | start_vld | alu_ifu_br_vld;
    assign vld_nxt   = start_vld | ifu_idu_vld & ~idu_ifu_wfi | alu_ifu_br_vld;

    always_comb begin
        if (start_vld) begin
            pc_nxt = {start_addr[core_pkg::pc_w-1:2], 2'b00};
        end else if (alu_ifu_br_vld) begin
            pc_nxt = alu_ifu_br_addr;
        end else begin
            pc_nxt = pc_plus;
        end
    end

    // new line on start, redirect or leaving slot 3
    assign mem_ce   = start_vld | alu_ifu_br_vld | ifu_idu_vld & idu_ifu_rdy & last_slot;
    assign mem_addr = pc_nxt[core_pkg::pc_w-1:4];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ifu_idu_vld <= 1'b0;
            pc          <= '0;
        end else begin
            ifu_idu_vld <= vld_nxt;
            if (pc_en) begin
                pc <= pc_nxt;
            end
        end
    end

    assign ifu_idu_ins = ifu_idu_ins_raw[32*pc[3:2] +: 32];  // word select
    assign ifu_idu_pc  = {{(32-core_pkg::pc_w){1'b0}}, pc};

endmodule

`default_nettype wire

// ==== prog_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module prog_loader (
    input  wire                               clk,
    input  wire                               arst_n,
    input  wire                               load_vld,
    input  wire  [31:0]                       load_word,
    output logic                              load_rdy,
    output logic                              wr_req,
    output logic [core_pkg::line_addr_w-1:0]  wr_addr,
    output logic [core_pkg::line_w-1:0]       wr_line,
    input  wire                               wr_gnt
);

    logic [1:0] slot;
    logic       take;

    assign load_rdy = ~wr_req;  // stall while a full line waits
    assign take     = load_vld & load_rdy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot    <= '0;
            wr_req  <= 1'b0;
            wr_addr <= '0;
        end else if (wr_gnt) begin
            wr_req  <= 1'b0;
            wr_addr <= wr_addr + 1'b1;
            slot    <= '0;
        end else if (take) begin
            slot <= slot + 1'b1;
            if (slot == 2'd3) begin
                wr_req <= 1'b1;  // line complete
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wr_line[32*slot +: 32] <= load_word;  // slot 0 is the low word
        end
    end

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire                               fetch_ce,
    input  wire  [core_pkg::line_addr_w-1:0]  fetch_addr,
    input  wire                               wr_req,
    input  wire  [core_pkg::line_addr_w-1:0]  wr_addr,
    input  wire  [core_pkg::line_w-1:0]       wr_line,
    output logic                              wr_gnt,
    output logic                              mem_ce,
    output logic                              mem_we,
    output logic [core_pkg::line_addr_w-1:0]  mem_addr,
    output logic [core_pkg::line_w-1:0]       mem_din
);

    // fetch reads always win the port
    assign wr_gnt = wr_req & ~fetch_ce;

    always_comb begin
        mem_ce   = fetch_ce | wr_req;
        mem_we   = wr_gnt;
        mem_din  = wr_line;
        if (fetch_ce) begin
            mem_addr = fetch_addr;
        end else begin
            mem_addr = wr_addr;  // loader line when fetch idle
        end
    end

endmodule

`default_nettype wire

// ==== mem_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_wrapper #(
    parameter int ADDR_WIDTH = 8,
    parameter int DATA_WIDTH = 128
) (
    input  wire                   clk,
    input  wire                   ce,
    input  wire                   we,
    input  wire  [ADDR_WIDTH-1:0] addr,
    input  wire  [DATA_WIDTH-1:0] din,
    output logic [DATA_WIDTH-1:0] dout
);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (ce) begin
            if (we) begin
                mem[addr] <= din;
            end else begin
                dout <= mem[addr];  // holds between reads
            end
        end
    end

endmodule

`default_nettype wire

// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int pc_w        = 12;   // 4 KB instruction space
    localparam int line_w      = 128;  // four words per line
    localparam int line_addr_w = 8;

    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_XOR = 2'd2
    } alu_op_e;

    typedef struct packed {
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [31:0] imm;      // sign extended
        alu_op_e     alu_op;
        logic        use_imm;
        logic        wr_en;
        logic        is_beq;
        logic        is_bne;
        logic        is_jal;
        logic        is_wfi;
    } dec_ins_t;

endpackage

`default_nettype wire
